// ==== alu_golden.txt ====
# W addr data | R addr expected | C op a_addr b_addr dst result carry
# P forks the next C line with the next R line; all fields hex
W 000 C8
W 001 64
W 002 05
W 003 09
W 004 96
W 005 3B
W 006 A5
W 007 F0
W 008 08
W 009 F9
W 00A 0B
W 00B FF
W 00C 0F
W 1FF 5A
R 000 C8
R 1FF 5A
R 004 96
R 00C 0F
C 0 000 001 020 2C 1
C 0 002 003 021 0E 0
C 1 002 003 022 FC 1
C 1 000 001 023 64 0
C 2 002 003 024 04 0
C 2 000 001 025 9C 1
C 3 004 005 026 42 0
C 3 00C 00C 027 E1 0
C 4 006 007 028 0A 0
C 5 006 007 029 5A 0
C 6 006 007 02A 5F 0
C 7 006 007 02B AA 0
C C 000 001 02C 00 0
C D 000 001 02D 00 0
C E 000 001 02E 00 0
C F 000 001 02F 00 0
C 8 004 008 040 96 0
C 8 004 009 041 4B 0
C 8 004 00A 042 12 0
C 8 004 00B 043 01 0
C 9 004 008 044 96 0
C 9 004 009 045 2C 0
C 9 004 00A 046 B0 0
C 9 004 00B 047 00 0
C A 004 008 048 96 0
C A 004 009 049 4B 0
C A 004 00A 04A D2 0
C A 004 00B 04B 2D 0
C B 004 008 04C 96 0
C B 004 009 04D 2D 0
C B 004 00A 04E B4 0
C B 004 00B 04F 4B 0
R 020 2C
R 022 FC
R 02B AA
R 04A D2
P
C 0 002 003 030 0E 0
R 006 A5
P
C 1 000 001 031 64 0
R 1FF 5A
R 030 0E
R 031 64

// ==== alu_system.f ====
+incdir+.
alu_pkg.sv
array_multiplier.sv
barrel_shifter.sv
alu_core.sv
word_memory.sv
mem_arbiter.sv
alu_sequencer.sv
alu_system.sv
tb_alu_system.sv

// ==== tb_alu_system.sv ====
//////////////////////////////
// testbench for the ALU system
// replays host writes and reads, commands and forked pairs from alu_golden.txt
// every response is compared with the value stored in the golden file
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module tb_alu_system
    import alu_pkg::*;
();

    // handshake waits give up after this many cycles
    localparam int TIMEOUT = 200;

    logic               clk;
    logic               reset;
    logic               host_req;
    mem_req_t           host_mem;
    logic               host_ack;
    logic [`WORD_W-1:0] host_rdata;
    logic               cmd_req;
    alu_cmd_t           cmd;
    logic               cmd_ack;
    logic [`WORD_W-1:0] result;
    logic               carry;

    int fd;

    alu_system dut (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_req),
        .host_mem   (host_mem),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .cmd_ack    (cmd_ack),
        .result     (result),
        .carry      (carry)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // reporting
    //////////////////////////////

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH at %0t ns: %s expected %h got %h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic require_fields(input int got, input int want, input string kind);
        if (got != want) begin
            $display("golden file has a malformed %s line", kind);
            abort_run();
        end
    endtask

    //////////////////////////////
    // handshake waits sampled on the falling edge
    //////////////////////////////

    task automatic wait_host_ack(input logic level, input string what);
        int n;
        n = 0;
        while (host_ack !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (host_ack !== level) begin
            $display("timeout: host_ack never went to %0d during %s", level, what);
            abort_run();
        end
    endtask

    task automatic wait_cmd_ack(input logic level, input string what);
        int n;
        n = 0;
        while (cmd_ack !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (cmd_ack !== level) begin
            $display("timeout: cmd_ack never went to %0d during %s", level, what);
            abort_run();
        end
    endtask

    //////////////////////////////
    // drivers
    //////////////////////////////

    // one four-phase host access with the read data checked under ack
    task automatic host_access(input logic we, input logic [`ADDR_W-1:0] addr,
                               input logic [`WORD_W-1:0] data);
        mem_req_t req_v;
        req_v.we    = we;
        req_v.addr  = addr;
        req_v.wdata = we ? data : '0;
        @(posedge clk);
        host_req <= 1'b1;
        host_mem <= req_v;
        @(negedge clk);
        wait_host_ack(1'b1, "host access");
        if (!we) begin
            check_value("host_rdata", data, host_rdata);
        end
        @(posedge clk);
        host_req <= 1'b0;
        @(negedge clk);
        // ack still up one edge after req went low
        check_value("host_ack", 8'd1, {7'd0, host_ack});
        wait_host_ack(1'b0, "host release");
    endtask

    // one command with result and flag checked while cmd_ack is high
    task automatic run_command(input logic [3:0] op_code, input logic [`ADDR_W-1:0] src_a,
                               input logic [`ADDR_W-1:0] src_b,
                               input logic [`ADDR_W-1:0] dst,
                               input logic [`WORD_W-1:0] exp_result, input logic exp_carry);
        alu_cmd_t cmd_v;
        cmd_v.op    = alu_op_e'(op_code);
        cmd_v.src_a = src_a;
        cmd_v.src_b = src_b;
        cmd_v.dst   = dst;
        @(posedge clk);
        cmd_req <= 1'b1;
        cmd     <= cmd_v;
        @(negedge clk);
        wait_cmd_ack(1'b1, "command");
        check_value("result", exp_result, result);
        check_value("carry", {7'd0, exp_carry}, {7'd0, carry});
        @(posedge clk);
        cmd_req <= 1'b0;
        @(negedge clk);
        check_value("cmd_ack", 8'd1, {7'd0, cmd_ack});
        wait_cmd_ack(1'b0, "command release");
    endtask

    // read the next line kind letter
    // blanks and # comment lines are skipped
    function automatic int next_kind(input int f);
        int c;
        c = $fgetc(f);
        while (c == " " || c == "\n" || c == "\r" || c == "\t" || c == "#") begin
            if (c == "#") begin
                while (c != "\n" && c != -1) begin
                    c = $fgetc(f);
                end
            end
            c = $fgetc(f);
        end
        return c;
    endfunction

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin : main
        int                 kind;
        int                 n;
        int                 lines;
        logic [3:0]         op_code;
        logic [`ADDR_W-1:0] addr_a;
        logic [`ADDR_W-1:0] addr_b;
        logic [`ADDR_W-1:0] addr_d;
        logic [`ADDR_W-1:0] addr_h;
        logic [`WORD_W-1:0] data_v;
        logic [`WORD_W-1:0] exp_r;
        logic               exp_c;

        lines      = 0;
        void'($urandom(92));
        reset      = 1'b1;
        host_req   = 1'b0;
        host_mem   = '0;
        cmd_req    = 1'b0;
        cmd        = '0;

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        // both acks idle out of reset
        check_value("host_ack", 8'd0, {7'd0, host_ack});
        check_value("cmd_ack", 8'd0, {7'd0, cmd_ack});

        fd = $fopen("alu_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open alu_golden.txt");
            abort_run();
        end

        kind = next_kind(fd);
        while (kind != -1) begin
            lines++;
            case (kind)
                "W": begin
                    n = $fscanf(fd, "%h %h", addr_h, data_v);
                    require_fields(n, 2, "W");
                    host_access(1'b1, addr_h, data_v);
                end
                "R": begin
                    n = $fscanf(fd, "%h %h", addr_h, data_v);
                    require_fields(n, 2, "R");
                    host_access(1'b0, addr_h, data_v);
                end
                "C": begin
                    n = $fscanf(fd, "%h %h %h %h %h %h",
                                op_code, addr_a, addr_b, addr_d, exp_r, exp_c);
                    require_fields(n, 6, "C");
                    run_command(op_code, addr_a, addr_b, addr_d, exp_r, exp_c);
                end
                // command and host read run side by side
                "P": begin
                    require_fields(next_kind(fd), "C", "P");
                    n = $fscanf(fd, "%h %h %h %h %h %h",
                                op_code, addr_a, addr_b, addr_d, exp_r, exp_c);
                    require_fields(n, 6, "P command");
                    require_fields(next_kind(fd), "R", "P");
                    n = $fscanf(fd, "%h %h", addr_h, data_v);
                    require_fields(n, 2, "P read");
                    fork
                        run_command(op_code, addr_a, addr_b, addr_d, exp_r, exp_c);
                        host_access(1'b0, addr_h, data_v);
                    join
                end
                default: begin
                    $display("golden file has an unknown line kind %c", kind);
                    abort_run();
                end
            endcase
            kind = next_kind(fd);
        end
        $fclose(fd);

        $display("replayed %0d golden lines", lines);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== alu_system.sv ====
//////////////////////////////
// top level of the ALU system
// host port and command port share one 512-word memory
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module alu_system
    import alu_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               host_req,
    input  mem_req_t           host_mem,
    output logic               host_ack,
    output logic [`WORD_W-1:0] host_rdata,
    input  logic               cmd_req,
    input  alu_cmd_t           cmd,
    output logic               cmd_ack,
    output logic [`WORD_W-1:0] result,
    output logic               carry
);

    // sequencer to arbiter, client 1
    logic               seq_req;
    logic               seq_ack;
    mem_req_t           seq_mem;
    logic [`WORD_W-1:0] client_rdata;

    // arbiter to memory
    logic               mem_en;
    mem_req_t           mem;
    logic [`WORD_W-1:0] mem_rdata;

    // sequencer to core
    alu_op_e            core_op;
    logic [`WORD_W-1:0] core_a;
    logic [`WORD_W-1:0] core_b;
    logic [`WORD_W-1:0] core_result;
    logic               core_carry;

    // both clients see the same read bus, valid under their own ack
    assign host_rdata = client_rdata;

    alu_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .cmd_req     (cmd_req),
        .cmd         (cmd),
        .cmd_ack     (cmd_ack),
        .result      (result),
        .carry       (carry),
        .seq_req     (seq_req),
        .seq_mem     (seq_mem),
        .seq_ack     (seq_ack),
        .seq_rdata   (client_rdata),
        .core_op     (core_op),
        .core_a      (core_a),
        .core_b      (core_b),
        .core_result (core_result),
        .core_carry  (core_carry)
    );

    alu_core u_core (
        .op     (core_op),
        .a      (core_a),
        .b      (core_b),
        .result (core_result),
        .carry  (core_carry)
    );

    mem_arbiter u_arb (
        .clk          (clk),
        .reset        (reset),
        .host_req     (host_req),
        .host_mem     (host_mem),
        .host_ack     (host_ack),
        .seq_req      (seq_req),
        .seq_mem      (seq_mem),
        .seq_ack      (seq_ack),
        .client_rdata (client_rdata),
        .mem_en       (mem_en),
        .mem          (mem),
        .rdata        (mem_rdata)
    );

    word_memory u_mem (
        .clk    (clk),
        .mem_en (mem_en),
        .mem    (mem),
        .rdata  (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== alu_sequencer.sv ====
//////////////////////////////
// command sequencer
// fetches A and B, computes, writes back to dst, then acks the command
// every memory access is a full four-phase handshake with the arbiter
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module alu_sequencer
    import alu_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               cmd_req,
    input  alu_cmd_t           cmd,
    output logic               cmd_ack,
    output logic [`WORD_W-1:0] result,
    output logic               carry,
    output logic               seq_req,
    output mem_req_t           seq_mem,
    input  logic               seq_ack,
    input  logic [`WORD_W-1:0] seq_rdata,
    output alu_op_e            core_op,
    output logic [`WORD_W-1:0] core_a,
    output logic [`WORD_W-1:0] core_b,
    input  logic [`WORD_W-1:0] core_result,
    input  logic               core_carry
);

    seq_state_e state;

    alu_cmd_t           cmd_r;
    logic [`WORD_W-1:0] opnd_a;
    logic [`WORD_W-1:0] opnd_b;

    // set once ack was seen and req dropped, waiting for ack low
    logic wait_low;
    logic in_access;
    logic ack_seen;
    logic acc_done;

    assign in_access = (state == ST_READ_A) || (state == ST_READ_B) || (state == ST_WRITE);
    assign ack_seen  = in_access && !wait_low && seq_ack;
    assign acc_done  = in_access && wait_low && !seq_ack;

    //////////////////////////////
    // control
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            seq_req  <= 1'b0;
            wait_low <= 1'b0;
            cmd_ack  <= 1'b0;
        end else begin
            // shared handshake tracking for the three access states
            if (ack_seen) begin
                seq_req  <= 1'b0;
                wait_low <= 1'b1;
            end
            if (acc_done) begin
                wait_low <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (cmd_req) begin
                        seq_req <= 1'b1;
                        state   <= ST_READ_A;
                    end
                end
                ST_READ_A: begin
                    if (acc_done) begin
                        seq_req <= 1'b1;
                        state   <= ST_READ_B;
                    end
                end
                ST_READ_B: begin
                    if (acc_done) begin
                        state <= ST_EXEC;
                    end
                end
                // core result is captured here, write-back starts next
                ST_EXEC: begin
                    seq_req <= 1'b1;
                    state   <= ST_WRITE;
                end
                ST_WRITE: begin
                    if (acc_done) begin
                        cmd_ack <= 1'b1;
                        state   <= ST_DONE;
                    end
                end
                // ack held until the host drops cmd_req
                ST_DONE: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // operands and result
    //////////////////////////////
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && cmd_req) begin
            cmd_r <= cmd;
        end
        if ((state == ST_READ_A) && ack_seen) begin
            opnd_a <= seq_rdata;
        end
        if ((state == ST_READ_B) && ack_seen) begin
            opnd_b <= seq_rdata;
        end
        if (state == ST_EXEC) begin
            result <= core_result;
            carry  <= core_carry;
        end
    end

    // request bundle follows the state, stable while seq_req is high
    always_comb begin
        seq_mem.we    = (state == ST_WRITE);
        seq_mem.wdata = result;
        case (state)
            ST_READ_B: seq_mem.addr = cmd_r.src_b;
            ST_WRITE:  seq_mem.addr = cmd_r.dst;
            default:   seq_mem.addr = cmd_r.src_a;
        endcase
    end

    assign core_op = cmd_r.op;
    assign core_a  = opnd_a;
    assign core_b  = opnd_b;

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
//////////////////////////////
// two-client round-robin memory arbiter
// client 0 is the host port, client 1 the command sequencer
// each client runs a four-phase req/ack handshake
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module mem_arbiter
    import alu_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               host_req,
    input  mem_req_t           host_mem,
    output logic               host_ack,
    input  logic               seq_req,
    input  mem_req_t           seq_mem,
    output logic               seq_ack,
    output logic [`WORD_W-1:0] client_rdata,
    output logic               mem_en,
    output mem_req_t           mem,
    input  logic [`WORD_W-1:0] rdata
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ISSUE,
        ARB_ACK,
        ARB_RELEASE
    } arb_state_e;

    arb_state_e state;

    // client served last, also selects the current winner
    logic last_served;
    logic pick;
    logic winner_req;

    // on a tie go to the client not served last
    always_comb begin
        if (host_req && seq_req) begin
            pick = ~last_served;
        end else begin
            pick = seq_req;
        end
    end

    assign winner_req = last_served ? seq_req : host_req;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ARB_IDLE;
            last_served <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (host_req || seq_req) begin
                        last_served <= pick;
                        state       <= ARB_ISSUE;
                    end
                end
                // memory access happens at the end of this cycle
                ARB_ISSUE: state <= ARB_ACK;
                // hold ack until the winner drops req
                ARB_ACK: begin
                    if (!winner_req) begin
                        state <= ARB_RELEASE;
                    end
                end
                ARB_RELEASE: state <= ARB_IDLE;
                default:     state <= ARB_IDLE;
            endcase
        end
    end

    assign mem_en = (state == ARB_ISSUE);
    assign mem    = last_served ? seq_mem : host_mem;

    assign host_ack = (state == ARB_ACK) && !last_served;
    assign seq_ack  = (state == ARB_ACK) && last_served;

    // registered read data stays put while ack is high
    assign client_rdata = rdata;

endmodule

`default_nettype wire

// ==== word_memory.sv ====
//////////////////////////////
// 512 x 8 single-port synchronous RAM
// driven only by the arbiter, read data one cycle after the access
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module word_memory
    import alu_pkg::*;
(
    input  logic               clk,
    input  logic               mem_en,
    input  mem_req_t           mem,
    output logic [`WORD_W-1:0] rdata
);

    logic [`WORD_W-1:0] ram [`MEM_DEPTH];

    // write when we is set, else read into the output register
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem.we) begin
                ram[mem.addr] <= mem.wdata;
            end else begin
                rdata <= ram[mem.addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== alu_core.sv ====
//////////////////////////////
// combinational ALU core
// decodes the opcode, gives the result and the carry/borrow flag
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module alu_core
    import alu_pkg::*;
(
    input  alu_op_e            op,
    input  logic [`WORD_W-1:0] a,
    input  logic [`WORD_W-1:0] b,
    output logic [`WORD_W-1:0] result,
    output logic               carry
);

    // extended by one bit so the top bit is carry or borrow
    logic [`WORD_W:0] add_ext;
    logic [`WORD_W:0] sub_ext;
    logic [`WORD_W:0] rsb_ext;

    logic [2*`MUL_W-1:0] mul_product;
    logic [`WORD_W-1:0]  shift_out;
    logic                shift_right;
    logic                shift_rotate;

    assign add_ext = {1'b0, a} + {1'b0, b};
    // top bit set when a < b
    assign sub_ext = {1'b0, a} - {1'b0, b};
    // top bit set when b < a
    assign rsb_ext = {1'b0, b} - {1'b0, a};

    //////////////////////////////
    // multiplier and shifter
    //////////////////////////////

    // low nibbles only
    array_multiplier u_mul (
        .a       (a[`MUL_W-1:0]),
        .b       (b[`MUL_W-1:0]),
        .product (mul_product)
    );

    assign shift_right  = (op == OP_SRL) || (op == OP_ROR);
    assign shift_rotate = (op == OP_ROR) || (op == OP_ROL);

    // amount is the low bits of b, upper bits ignored
    barrel_shifter u_shift (
        .data      (a),
        .shamt     (b[`SHAMT_W-1:0]),
        .dir_right (shift_right),
        .rotate    (shift_rotate),
        .shifted   (shift_out)
    );

    //////////////////////////////
    // result select
    //////////////////////////////
    always_comb begin
        result = '0;
        carry  = 1'b0;
        case (op)
            OP_ADD: begin
                result = add_ext[`WORD_W-1:0];
                carry  = add_ext[`WORD_W];
            end
            OP_SUB: begin
                result = sub_ext[`WORD_W-1:0];
                carry  = sub_ext[`WORD_W];
            end
            OP_RSB: begin
                result = rsb_ext[`WORD_W-1:0];
                carry  = rsb_ext[`WORD_W];
            end
            OP_MUL:  result = mul_product;
            OP_NOR:  result = ~(a | b);
            OP_NOT:  result = ~a;
            OP_NAND: result = ~(a & b);
            OP_XNOR: result = ~(a ^ b);
            OP_SRL, OP_SLL, OP_ROR, OP_ROL: result = shift_out;
            // NOP and codes 13 to 15
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== barrel_shifter.sv ====
//////////////////////////////
// logarithmic shifter for the ALU
// shift or rotate left/right by 0 to 7 places
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module barrel_shifter (
    input  logic [`WORD_W-1:0]  data,
    input  logic [`SHAMT_W-1:0] shamt,
    input  logic                dir_right,
    input  logic                rotate,
    output logic [`WORD_W-1:0]  shifted
);

    localparam int W = `WORD_W;

    // stage k holds data moved by the low k bits of shamt
    logic [W-1:0] stage [`SHAMT_W+1];

    assign stage[0] = data;

    genvar k;

    generate
        for (k = 0; k < `SHAMT_W; k++) begin : g_stage
            localparam int S = 1 << k;

            logic [S-1:0] fill_r;
            logic [S-1:0] fill_l;
            logic [W-1:0] moved;

            // vacated bits: zeros for a shift, pushed-out bits for a rotate
            assign fill_r = rotate ? stage[k][S-1:0] : '0;
            assign fill_l = rotate ? stage[k][W-1:W-S] : '0;

            assign moved = dir_right ? {fill_r, stage[k][W-1:S]}
                                     : {stage[k][W-1-S:0], fill_l};

            // bit k of shamt enables a move by 2**k places
            assign stage[k+1] = shamt[k] ? moved : stage[k];
        end
    endgenerate

    assign shifted = stage[`SHAMT_W];

endmodule

`default_nettype wire

// ==== array_multiplier.sv ====
//////////////////////////////
// unsigned array multiplier, MUL_W x MUL_W bits
// one AND row per multiplier bit, summed layer by layer
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module array_multiplier (
    input  logic [`MUL_W-1:0]   a,
    input  logic [`MUL_W-1:0]   b,
    output logic [2*`MUL_W-1:0] product
);

    localparam int N = `MUL_W;

    // partial product rows, a gated by each bit of b
    logic [N-1:0] row [N];

    // upper partial sum handed from one layer to the next
    logic [N-1:0] pp [N];

    genvar i;

    //////////////////////////////
    // layers
    //////////////////////////////
    generate
        for (i = 0; i < N; i++) begin : g_layer
            logic [N:0] sum;

            assign row[i] = a & {N{b[i]}};

            if (i == 0) begin : g_first
                // nothing to accumulate yet
                assign sum = {1'b0, row[i]};
            end else begin : g_rest
                // row i lines up with bit 0 of the previous upper sum
                assign sum = {1'b0, row[i]} + {1'b0, pp[i-1]};
            end

            // low bit is final, the rest moves on
            assign product[i] = sum[0];
            assign pp[i]      = sum[N:1];
        end
    endgenerate

    // last layer's upper sum is the top half of the product
    assign product[2*N-1:N] = pp[N-1];

endmodule

`default_nettype wire

// ==== alu_pkg.sv ====
//////////////////////////////
// shared types of the ALU system
// opcodes, command and memory request bundles, sequencer states
//////////////////////////////
`default_nettype none

`include "alu_cfg.svh"

package alu_pkg;

    // ALU opcodes, codes 13 to 15 fall back to NOP in the core
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_RSB  = 4'd2,
        OP_MUL  = 4'd3,
        OP_NOR  = 4'd4,
        OP_NOT  = 4'd5,
        OP_NAND = 4'd6,
        OP_XNOR = 4'd7,
        OP_SRL  = 4'd8,
        OP_SLL  = 4'd9,
        OP_ROR  = 4'd10,
        OP_ROL  = 4'd11,
        OP_NOP  = 4'd12
    } alu_op_e;

    // one command: op, two source addresses, one destination
    typedef struct packed {
        alu_op_e             op;
        logic [`ADDR_W-1:0]  src_a;
        logic [`ADDR_W-1:0]  src_b;
        logic [`ADDR_W-1:0]  dst;
    } alu_cmd_t;

    // memory access as seen by the arbiter clients
    typedef struct packed {
        logic                we;
        logic [`ADDR_W-1:0]  addr;
        logic [`WORD_W-1:0]  wdata;
    } mem_req_t;

    // command sequencer phases
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_A,
        ST_READ_B,
        ST_EXEC,
        ST_WRITE,
        ST_DONE
    } seq_state_e;

endpackage

`default_nettype wire

// ==== alu_cfg.svh ====
//////////////////////////////
// sizing macros for the 8-bit ALU system
// include in any file that needs word, address or shifter widths
//////////////////////////////
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// data path width
`define WORD_W 8

// memory address width and word count
`define ADDR_W 9
`define MEM_DEPTH 512

// operand width of the nibble multiplier
`define MUL_W 4

// shift amount width, taken from the low bits of operand b
`define SHAMT_W 3

`endif
